// File: rv32i_types.sv
`default_nettype none

package rv32i_types;

    // architectural widths
    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;

    // first fetch address out of reset
    localparam pc_t RESET_PC = 32'h1eceb000;

    // one queued fetch result, 64 bits
    typedef struct packed {
        pc_t   pc;   // address the word came from
        inst_t inst; // raw instruction bits
    } fetch_entry_t;

endpackage : rv32i_types

`default_nettype wire

// File: mem_types.sv
`default_nettype none

package mem_types;

    // line and burst geometry
    localparam int unsigned LINE_BITS      = 256;
    localparam int unsigned BEAT_BITS      = 64;
    localparam int unsigned BEATS_PER_LINE = LINE_BITS / BEAT_BITS;

    // direct-mapped cache layout, 16 sets of 32 bytes
    localparam int unsigned NUM_SETS    = 16;
    localparam int unsigned OFFSET_BITS = 5;
    localparam int unsigned INDEX_BITS  = 4;
    localparam int unsigned TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS; // 23

    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [BEAT_BITS-1:0] beat_t;
    typedef logic [TAG_BITS-1:0]  tag_t;

endpackage : mem_types

`default_nettype wire

// File: ufp_if.sv
`timescale 1ns/1ps
`default_nettype none

// fetch unit to instruction cache
interface ufp_if;

    rv32i_types::pc_t   addr;
    logic [3:0]         rmask;  // nonzero for one cycle per request
    rv32i_types::inst_t rdata;
    logic               resp;   // single pulse, one per request

    modport requester (output addr, output rmask, input rdata, input resp);

    modport responder (input addr, input rmask, output rdata, output resp);

endinterface : ufp_if

`default_nettype wire

// File: dfp_if.sv
`timescale 1ns/1ps
`default_nettype none

// instruction cache to cacheline adapter
interface dfp_if;

    rv32i_types::pc_t addr;  // line aligned
    logic             read;  // level, held until resp
    mem_types::line_t rdata;
    logic             resp;  // one cycle, carries the whole line

    modport requester (output addr, output read, input rdata, input resp);

    modport responder (input addr, input read, output rdata, output resp);

endinterface : dfp_if

`default_nettype wire

// File: cacheline_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module cacheline_adapter (
    input  wire logic                clk,
    input  wire logic                rst,
    dfp_if.responder                 dfp,
    output      rv32i_types::pc_t    bmem_addr,
    output      logic                bmem_read,
    input  wire logic                bmem_ready,
    input  wire mem_types::beat_t    bmem_rdata,
    input  wire logic                bmem_rvalid
);

    logic read_q;       // dfp read one cycle ago
    logic issue_q;      // request seen but memory was busy
    logic want_issue;
    logic last_beat;
    logic resp_q;

    logic [$clog2(mem_types::BEATS_PER_LINE)-1:0] beat_cnt;
    mem_types::line_t                             line_q;

    // new request on the rising edge of read, or a retry
    assign want_issue = (dfp.read && !read_q) || issue_q;
    assign bmem_read  = want_issue && bmem_ready;
    assign bmem_addr  = dfp.addr;   // cache holds it stable while read is high

    assign last_beat = (beat_cnt == $bits(beat_cnt)'(mem_types::BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            read_q   <= 1'b0;
            issue_q  <= 1'b0;
            beat_cnt <= '0;
            resp_q   <= 1'b0;
        end else begin
            read_q   <= dfp.read;
            issue_q  <= want_issue && !bmem_ready;
            resp_q   <= bmem_rvalid && last_beat;
            if (bmem_rvalid)
                beat_cnt <= beat_cnt + 1'b1;    // wraps to zero after the last beat
        end
    end

    // beats arrive lowest first, so shift in from the top
    always_ff @(posedge clk) begin
        if (bmem_rvalid)
            line_q <= {bmem_rdata, line_q[mem_types::LINE_BITS-1:mem_types::BEAT_BITS]};
    end

    assign dfp.rdata = line_q;
    assign dfp.resp  = resp_q;

endmodule : cacheline_adapter

`default_nettype wire

// File: icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
    input wire logic clk,
    input wire logic rst,
    ufp_if.responder ufp,
    dfp_if.requester dfp
);

    typedef enum logic {
        IDLE,
        FILL
    } state_t;

    state_t state;

    // storage
    logic [mem_types::NUM_SETS-1:0] valid;
    mem_types::tag_t                tag_arr  [mem_types::NUM_SETS];
    mem_types::line_t               data_arr [mem_types::NUM_SETS];

    // incoming request split
    logic                                req;
    logic                                hit;
    mem_types::tag_t                     req_tag;
    logic [mem_types::INDEX_BITS-1:0]    req_idx;
    logic [mem_types::OFFSET_BITS-3:0]   req_off;   // word within the line

    // request latched for the fill
    rv32i_types::pc_t                    addr_q;
    mem_types::tag_t                     fill_tag;
    logic [mem_types::INDEX_BITS-1:0]    fill_idx;
    logic [mem_types::OFFSET_BITS-3:0]   fill_off;

    logic               resp_q;
    rv32i_types::inst_t rdata_q;

    function automatic rv32i_types::inst_t pick_word(
        input mem_types::line_t                   line,
        input logic [mem_types::OFFSET_BITS-3:0]  off
    );
        return line[off*$bits(rv32i_types::inst_t) +: $bits(rv32i_types::inst_t)];
    endfunction

    assign req     = (|ufp.rmask) && (state == IDLE);
    assign req_tag = ufp.addr[31 -: mem_types::TAG_BITS];
    assign req_idx = ufp.addr[mem_types::OFFSET_BITS +: mem_types::INDEX_BITS];
    assign req_off = ufp.addr[mem_types::OFFSET_BITS-1:2];
    assign hit     = valid[req_idx] && (tag_arr[req_idx] == req_tag);

    assign fill_tag = addr_q[31 -: mem_types::TAG_BITS];
    assign fill_idx = addr_q[mem_types::OFFSET_BITS +: mem_types::INDEX_BITS];
    assign fill_off = addr_q[mem_types::OFFSET_BITS-1:2];

    // miss FSM and valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            resp_q <= 1'b0;
            valid  <= '0;
        end else begin
            resp_q <= 1'b0;
            unique case (state)
                IDLE: begin
                    if (req && hit)
                        resp_q <= 1'b1;             // answer next cycle
                    else if (req)
                        state <= FILL;
                end
                FILL: begin
                    if (dfp.resp) begin
                        valid[fill_idx] <= 1'b1;
                        resp_q          <= 1'b1;
                        state           <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // arrays and returned word
    always_ff @(posedge clk) begin
        if (req)
            addr_q <= ufp.addr;
        if (req && hit)
            rdata_q <= pick_word(data_arr[req_idx], req_off);
        if (state == FILL && dfp.resp) begin
            tag_arr[fill_idx]  <= fill_tag;
            data_arr[fill_idx] <= dfp.rdata;
            rdata_q            <= pick_word(dfp.rdata, fill_off);  // critical word from new line
        end
    end

    assign dfp.read  = (state == FILL);
    assign dfp.addr  = {addr_q[31:mem_types::OFFSET_BITS], {mem_types::OFFSET_BITS{1'b0}}};
    assign ufp.resp  = resp_q;
    assign ufp.rdata = rdata_q;

endmodule : icache

`default_nettype wire

// File: fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter type         payload_t = logic [63:0],
    parameter int unsigned DEPTH     = 8                // power of two
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire payload_t                wdata,
    input  wire logic                    enq,
    output      payload_t                rdata,
    input  wire logic                    deq,
    output      logic                    full,
    output      logic                    empty,
    output      logic [$clog2(DEPTH):0]  count
);

    payload_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic                     do_enq;
    logic                     do_deq;

    assign do_enq = enq && !full;   // a push into a full queue is dropped
    assign do_deq = deq && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq)
                wr_ptr <= wr_ptr + 1'b1;    // pointers wrap at DEPTH
            if (do_deq)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_enq && !do_deq)
                count <= count + 1'b1;
            else if (do_deq && !do_enq)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq)
            mem[wr_ptr] <= wdata;
    end

    assign rdata = mem[rd_ptr];
    assign full  = (count == ($clog2(DEPTH)+1)'(DEPTH));
    assign empty = (count == '0);

endmodule : fetch_queue

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int unsigned DEPTH = 8
) (
    input  wire logic                clk,
    input  wire logic                rst,
    ufp_if.requester                 ufp,
    output      logic                inst_valid,
    output      rv32i_types::pc_t    inst_pc,
    output      rv32i_types::inst_t  inst,
    input  wire logic                inst_deq
);

    rv32i_types::pc_t          pc;
    logic                      outstanding;    // request sent, no resp yet
    logic [3:0]                rmask_q;
    logic                      issue;

    rv32i_types::fetch_entry_t enq_entry;
    rv32i_types::fetch_entry_t head;
    logic                      q_full;
    logic                      q_empty;
    logic [$clog2(DEPTH):0]    q_count;

    // only issue when the result is sure to have a slot
    assign issue = !outstanding && !q_full && ((32'(q_count) + 32'(outstanding)) < DEPTH);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= rv32i_types::RESET_PC;
            outstanding <= 1'b0;
            rmask_q     <= '0;
        end else begin
            rmask_q <= issue ? 4'hf : 4'h0; // one-cycle strobe
            if (issue)
                outstanding <= 1'b1;
            else if (ufp.resp)
                outstanding <= 1'b0;
            if (ufp.resp)
                pc <= pc + 32'd4;
        end
    end

    assign ufp.addr  = pc;      // pc only moves on resp, so stable through the request
    assign ufp.rmask = rmask_q;

    assign enq_entry = '{pc: pc, inst: ufp.rdata};

    fetch_queue #(
        .payload_t (rv32i_types::fetch_entry_t),
        .DEPTH     (DEPTH)
    ) queue_i (
        .clk   (clk),
        .rst   (rst),
        .wdata (enq_entry),
        .enq   (ufp.resp),
        .rdata (head),
        .deq   (inst_deq),
        .full  (q_full),
        .empty (q_empty),
        .count (q_count)
    );

    assign inst_valid = !q_empty;
    assign inst_pc    = head.pc;
    assign inst       = head.inst;

endmodule : fetch_unit

`default_nettype wire

// File: cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  wire logic                clk,
    input  wire logic                rst,

    // burst memory
    output      rv32i_types::pc_t    bmem_addr,
    output      logic                bmem_read,
    input  wire logic                bmem_ready,
    input  wire mem_types::beat_t    bmem_rdata,
    input  wire logic                bmem_rvalid,

    // instruction consumer
    output      logic                inst_valid,
    output      rv32i_types::pc_t    inst_pc,
    output      rv32i_types::inst_t  inst,
    input  wire logic                inst_deq
);

    ufp_if ufp ();
    dfp_if dfp ();

    fetch_unit #(
        .DEPTH (8)
    ) fetch_i (
        .clk        (clk),
        .rst        (rst),
        .ufp        (ufp.requester),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst       (inst),
        .inst_deq   (inst_deq)
    );

    icache cache_i (
        .clk (clk),
        .rst (rst),
        .ufp (ufp.responder),
        .dfp (dfp.requester)
    );

    cacheline_adapter adapter_i (
        .clk         (clk),
        .rst         (rst),
        .dfp         (dfp.responder),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_ready  (bmem_ready),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

endmodule : cpu

`default_nettype wire

// File: cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// handshake properties on the cpu top-level ports
module cpu_asserts (
    input wire logic             clk,
    input wire logic             rst,
    input wire logic             bmem_read,
    input wire logic             inst_valid,
    input wire rv32i_types::pc_t inst_pc,
    input wire logic             inst_deq
);

    int unsigned fail_count = 0;    // failed assertions so far

    // one pulse per line request
    read_is_pulse: assert property (@(posedge clk) disable iff (rst) bmem_read |=> !bmem_read)
        else begin
            fail_count++;
            $error("bmem_read high in two consecutive cycles");
        end

    queue_empty_after_reset: assert property (@(posedge clk) rst |=> !inst_valid)
        else begin
            fail_count++;
            $error("inst_valid high in the cycle after reset");
        end

    // head entry must not move unless it was taken
    head_stable: assert property (@(posedge clk) disable iff (rst)
        (inst_valid && !inst_deq) |=> $stable(inst_pc))
        else begin
            fail_count++;
            $error("inst_pc changed while the head was not dequeued");
        end

endmodule : cpu_asserts

`default_nettype wire

// File: tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int unsigned QUEUE_DEPTH = 8;    // depth set in cpu

    typedef enum {DEQ_HOLD, DEQ_ALL, DEQ_RANDOM} deq_mode_t;

    logic               clk;
    logic               rst;
    rv32i_types::pc_t   bmem_addr;
    logic               bmem_read;
    logic               bmem_ready;
    mem_types::beat_t   bmem_rdata;
    logic               bmem_rvalid;
    logic               inst_valid;
    rv32i_types::pc_t   inst_pc;
    rv32i_types::inst_t inst;
    logic               inst_deq;

    logic [31:0]        lcg_state = 32'h986a_e109;
    deq_mode_t          deq_mode = DEQ_HOLD;
    string              test_name = "reset_state";
    rv32i_types::pc_t   expected_pc = rv32i_types::RESET_PC;
    rv32i_types::pc_t   read_addrs[$];     // bmem_addr of every bmem_read pulse
    int                 n_deq = 0;
    int                 errors = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;

    cpu dut_i (
        .clk         (clk),
        .rst         (rst),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_ready  (bmem_ready),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid),
        .inst_valid  (inst_valid),
        .inst_pc     (inst_pc),
        .inst        (inst),
        .inst_deq    (inst_deq)
    );

    bind cpu cpu_asserts asserts_i (
        .clk        (clk),
        .rst        (rst),
        .bmem_read  (bmem_read),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst_deq   (inst_deq)
    );

    // LCG step, result reduced to 0..n-1
    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % n;
    endfunction

    // memory contents: fixed mix of the byte address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h1357_9bdf ^ {a[7:0], a[31:8]};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic timeout_error(input string what);
        errors++;
        $display("%s: timed out", what);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic wait_deq_count(input int target, input int max_cycles, input string name);
        int n;
        n = 0;
        while (n_deq < target && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (n_deq < target)
            timeout_error($sformatf("%s waiting for %0d entries, got %0d", name, target, n_deq));
    endtask

    // stop draining, let the queue fill, then match memory reads to lines fetched
    task automatic check_line_reads(input string name);
        rv32i_types::pc_t last_pc;
        int               lines;
        deq_mode = DEQ_HOLD;
        repeat (150) @(negedge clk);
        last_pc = expected_pc + 4 * (QUEUE_DEPTH - 1);  // full queue starts at expected_pc
        lines = ((last_pc - rv32i_types::RESET_PC) >> mem_types::OFFSET_BITS) + 1;
        check_value({name, " read count"}, lines, read_addrs.size());
        foreach (read_addrs[i])
            check_value({name, " read addr"},
                        rv32i_types::RESET_PC + (i << mem_types::OFFSET_BITS), read_addrs[i]);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // burst memory: one line at a time, random start delay and beat gaps
    initial begin : memory_model
        bit               pend;
        int               wait_cnt;
        int               beat_idx;
        rv32i_types::pc_t line_addr;
        pend        = 1'b0;
        wait_cnt    = 0;
        beat_idx    = 0;
        line_addr   = '0;
        bmem_ready  = 1'b0;
        bmem_rvalid = 1'b0;
        bmem_rdata  = '0;
        forever begin
            @(posedge clk);
            if (!rst && bmem_read) begin
                read_addrs.push_back(bmem_addr);
                line_addr = bmem_addr;
                pend      = 1'b1;
                beat_idx  = 0;
                wait_cnt  = rand_below(6);  // first beat 1 to 6 cycles later
            end
            #1;
            bmem_rvalid = 1'b0;
            bmem_ready  = (rand_below(4) != 0);
            if (pend) begin
                if (wait_cnt > 0) begin
                    wait_cnt--;
                end else begin
                    bmem_rvalid = 1'b1;
                    bmem_rdata  = {mem_word(line_addr + 8 * beat_idx + 4),
                                   mem_word(line_addr + 8 * beat_idx)};
                    beat_idx++;
                    if (beat_idx == mem_types::BEATS_PER_LINE)
                        pend = 1'b0;
                    else
                        wait_cnt = rand_below(3);
                end
            end
        end
    end

    // consumer and compare process
    initial begin : consumer
        inst_deq = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && inst_valid && inst_deq) begin
                check_value({test_name, " pc"}, expected_pc, inst_pc);
                check_value({test_name, " inst"}, mem_word(expected_pc), inst);
                expected_pc = expected_pc + 4;
                n_deq++;
            end
            #1;
            case (deq_mode)
                DEQ_ALL:    inst_deq = 1'b1;
                DEQ_RANDOM: inst_deq = (rand_below(3) != 0);
                default:    inst_deq = 1'b0;
            endcase
        end
    end

    initial begin : main
        int err0;
        int start;
        int n;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        test_name = "reset_state";
        err0 = errors;
        check_value("reset_state bmem_read", 0, bmem_read);
        check_value("reset_state inst_valid", 0, inst_valid);
        n = 0;
        while (bmem_read !== 1'b1 && n < 50) begin
            @(negedge clk);
            if (bmem_read !== 1'b1)
                check_value("reset_state inst_valid", 0, inst_valid);
            n++;
        end
        if (bmem_read !== 1'b1)
            timeout_error("reset_state waiting for the first bmem_read");
        n = 0;
        while (inst_valid !== 1'b1 && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (inst_valid !== 1'b1)
            timeout_error("reset_state waiting for inst_valid");
        check_value("reset_state first pc", rv32i_types::RESET_PC, inst_pc);
        report_test("reset_state", err0);

        test_name = "sequential_fetch";
        err0 = errors;
        deq_mode = DEQ_ALL;
        wait_deq_count(64, 64 * 40, "sequential_fetch");
        report_test("sequential_fetch", err0);

        test_name = "line_reuse";
        err0 = errors;
        check_line_reads("line_reuse");
        report_test("line_reuse", err0);

        // queue is full and held at this point
        test_name = "back_pressure";
        err0 = errors;
        repeat (100) begin
            @(negedge clk);
            check_value("back_pressure inst_valid", 1, inst_valid);
            check_value("back_pressure head pc", expected_pc, inst_pc);
        end
        start = n_deq;
        deq_mode = DEQ_ALL;
        wait_deq_count(start + 16, 16 * 40, "back_pressure");
        report_test("back_pressure", err0);

        test_name = "random_drain";
        err0 = errors;
        start = n_deq;
        deq_mode = DEQ_RANDOM;
        wait_deq_count(start + 200, 200 * 60, "random_drain");
        report_test("random_drain", err0);

        test_name = "capacity_wrap";
        err0 = errors;
        start = n_deq;
        deq_mode = DEQ_ALL;
        wait_deq_count(start + 40, 40 * 40, "capacity_wrap");
        check_line_reads("capacity_wrap");
        check_value("capacity_wrap index wrapped", 1, read_addrs.size() > mem_types::NUM_SETS);
        report_test("capacity_wrap", err0);

        errors = errors + int'(dut_i.asserts_i.fail_count);
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule : tb_cpu

`default_nettype wire

// File: sim.f
rv32i_types.sv
mem_types.sv
ufp_if.sv
dfp_if.sv
cacheline_adapter.sv
icache.sv
fetch_queue.sv
fetch_unit.sv
cpu.sv
cpu_asserts.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f sim.f -o tb_cpu_sim || exit 1
out=$(./obj_dir/tb_cpu_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && exit 0 || exit 1
